// File: verilog/la_defines.svh
// ****************************************
// Logic analyzer global sizes
// Sample, capture address, bank address and
// hit counter widths shared by all blocks
// ****************************************

`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

// Probe sample width
`define LA_SAMPLE_W     16

// Capture address, covers 1024 narrow entries
`define LA_ADDR_W       10

// One bank holds half a wide sample per entry
`define LA_BANK_AW      9

`define LA_BANK_DEPTH   (1 << `LA_BANK_AW)

// Trigger hit counter
`define LA_CNT_W        8

`endif

// File: verilog/la_pkg.sv
// ****************************************
// Logic analyzer types
// Sample, address, configuration and write
// request types plus trigger conditions
// ****************************************

`default_nettype none

`include "la_defines.svh"

package la_pkg;

    typedef logic [`LA_SAMPLE_W-1:0]   sample_t;
    typedef logic [`LA_SAMPLE_W/2-1:0] byte_t;
    typedef logic [`LA_ADDR_W-1:0]     addr_t;
    typedef logic [`LA_BANK_AW-1:0]    bank_addr_t;
    typedef logic [`LA_CNT_W-1:0]      cnt_t;

    // Per-bit trigger condition
    typedef enum logic [1:0] {
        dont_care = 2'd0,
        level     = 2'd1,
        rise      = 2'd2,
        fall      = 2'd3
    } trig_cond_e;

    // ****************************************
    // Host configuration
    // ****************************************
    typedef struct packed {
        sample_t                          pattern;
        trig_cond_e [`LA_SAMPLE_W-1:0]    cond;
        logic                             or_logic;
        addr_t                            max_addr;
        addr_t                            pre_num;
        logic                             store_wide;
        logic                             dbg_mode;
        logic                             cnt_wrap;
    } la_cfg_t;

    // Full-width capture write
    typedef struct packed {
        logic    vld;
        addr_t   addr;
        sample_t data;
    } mem_wr_t;

    // Byte write into one bank
    typedef struct packed {
        logic       en;
        bank_addr_t addr;
        byte_t      data;
    } bank_wr_t;

endpackage

`default_nettype wire

// File: verilog/trigger.sv
// ****************************************
// Trigger unit
// Writes samples into a circular window, holds
// pre-trigger history, matches the per-bit
// pattern and counts trigger hits
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "la_defines.svh"

module trigger (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire la_pkg::la_cfg_t    cfg,
    input  wire                     capture_enable,
    input  wire                     capture_start,
    input  wire la_pkg::sample_t    smp_data,
    input  wire                     smp_vld,
    input  wire                     cnt_clr,
    output la_pkg::mem_wr_t         tri_wr,
    output logic                    triggered,
    output la_pkg::addr_t           tri_addr,
    output la_pkg::addr_t           read_start_addr,
    output logic                    capture_done,
    output la_pkg::cnt_t            hit_cnt
);
    import la_pkg::*;

    logic    armed;
    logic    done_pend;
    addr_t   cur_addr;
    addr_t   pre_cnt;
    addr_t   post_cnt;
    addr_t   post_num;
    addr_t   start_calc;
    sample_t prev_smp;
    sample_t bit_hit;
    sample_t bit_care;
    logic    match;
    logic    accept;
    logic    fire;
    logic    wr_vld;
    addr_t   wr_addr_q;
    sample_t wr_data_q;

    // ****************************************
    // Pattern match
    // ****************************************
    always_comb begin
        for (int i = 0; i < `LA_SAMPLE_W; i++) begin
            bit_care[i] = (cfg.cond[i] != dont_care);
            case (cfg.cond[i])
                level:   bit_hit[i] = (smp_data[i] == cfg.pattern[i]);
                rise:    bit_hit[i] = ~prev_smp[i] & smp_data[i];
                fall:    bit_hit[i] = prev_smp[i] & ~smp_data[i];
                default: bit_hit[i] = 1'b0;
            endcase
        end
    end

    // Don't-care bits drop out of both AND and OR
    assign match  = cfg.or_logic ? |(bit_hit & bit_care) : &(bit_hit | ~bit_care);
    assign accept = armed & capture_enable & smp_vld & ~capture_start;
    assign fire   = accept & ~triggered & (pre_cnt == cfg.pre_num) & match;

    // Samples still owed after the trigger sample
    assign post_num = cfg.max_addr - cfg.pre_num;

    // Window start, tri_addr - pre_num modulo max_addr+1
    assign start_calc = (cur_addr >= cfg.pre_num) ? cur_addr - cfg.pre_num
                                                  : cur_addr + post_num + addr_t'(1);

    // ****************************************
    // Capture control
    // ****************************************
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            armed        <= 1'b0;
            triggered    <= 1'b0;
            capture_done <= 1'b0;
            done_pend    <= 1'b0;
            wr_vld       <= 1'b0;
            cur_addr     <= '0;
            pre_cnt      <= '0;
            post_cnt     <= '0;
            prev_smp     <= '0;
        end else begin
            wr_vld    <= accept;
            done_pend <= 1'b0;
            if (done_pend)
                capture_done <= 1'b1;
            // Edge reference is the last valid sample
            if (smp_vld)
                prev_smp <= smp_data;
            if (capture_start) begin
                armed        <= 1'b1;
                triggered    <= 1'b0;
                capture_done <= 1'b0;
                cur_addr     <= '0;
                pre_cnt      <= '0;
                post_cnt     <= '0;
            end else if (accept) begin
                cur_addr <= (cur_addr == cfg.max_addr) ? '0 : cur_addr + addr_t'(1);
                if (!triggered) begin
                    if (pre_cnt != cfg.pre_num)
                        pre_cnt <= pre_cnt + addr_t'(1);
                    if (fire) begin
                        triggered <= 1'b1;
                        if (post_num == '0) begin
                            armed     <= 1'b0;
                            done_pend <= 1'b1;
                        end
                    end
                end else begin
                    post_cnt <= post_cnt + addr_t'(1);
                    if (post_cnt + addr_t'(1) == post_num) begin
                        armed     <= 1'b0;
                        done_pend <= 1'b1;
                    end
                end
            end
        end
    end

    // Write payload and trigger position
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr_q <= cur_addr;
            wr_data_q <= smp_data;
        end
        if (fire) begin
            tri_addr        <= cur_addr;
            read_start_addr <= start_calc;
        end
    end

    // Hit counter, saturating unless wrap is set
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n)
            hit_cnt <= '0;
        else if (cnt_clr)
            hit_cnt <= '0;
        else if (fire && (cfg.cnt_wrap || hit_cnt != '1))
            hit_cnt <= hit_cnt + cnt_t'(1);
    end

    assign tri_wr = '{vld: wr_vld, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire

// File: verilog/ram_wr_ctrl.sv
// ****************************************
// Capture write controller
// Picks debug or trigger writes and splits
// each one into two byte-wide bank writes
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "la_defines.svh"

module ram_wr_ctrl (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dbg_mode,
    input  wire                     store_wide,
    input  wire la_pkg::mem_wr_t    tri_wr,
    input  wire la_pkg::mem_wr_t    dbg_wr,
    output la_pkg::bank_wr_t        bank0_wr,
    output la_pkg::bank_wr_t        bank1_wr
);
    import la_pkg::*;

    mem_wr_t    src_wr;
    logic       sel_vld;
    addr_t      sel_addr;
    sample_t    sel_data;
    logic       hi_half;
    logic       b0_en;
    logic       b1_en;
    bank_addr_t b_addr;
    byte_t      b0_data;
    byte_t      b1_data;

    // Debug mode bypasses the trigger path
    assign src_wr = dbg_mode ? dbg_wr : tri_wr;

    // ****************************************
    // Stage 1 select register
    // ****************************************
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n)
            sel_vld <= 1'b0;
        else
            sel_vld <= src_wr.vld;
    end

    always_ff @(posedge clk) begin
        sel_addr <= src_wr.addr;
        sel_data <= src_wr.data;
    end

    // Narrow mode bank select
    assign hi_half = sel_addr[`LA_ADDR_W-1];

    // ****************************************
    // Stage 2 bank split
    // ****************************************
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            b0_en <= 1'b0;
            b1_en <= 1'b0;
        end else begin
            b0_en <= sel_vld & (store_wide | ~hi_half);
            b1_en <= sel_vld & (store_wide | hi_half);
        end
    end

    always_ff @(posedge clk) begin
        if (sel_vld) begin
            b_addr  <= sel_addr[`LA_BANK_AW-1:0];
            b0_data <= sel_data[`LA_SAMPLE_W/2-1:0];
            // Wide keeps the high byte, narrow only ever stores low bytes
            b1_data <= store_wide ? sel_data[`LA_SAMPLE_W-1:`LA_SAMPLE_W/2]
                                  : sel_data[`LA_SAMPLE_W/2-1:0];
        end
    end

    assign bank0_wr = '{en: b0_en, addr: b_addr, data: b0_data};
    assign bank1_wr = '{en: b1_en, addr: b_addr, data: b1_data};

endmodule

`default_nettype wire

// File: verilog/capture_ram.sv
// ****************************************
// Capture memory bank
// Byte-wide synchronous RAM, one write port
// and one registered read port
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "la_defines.svh"

module capture_ram (
    input  wire                     clk,
    input  wire la_pkg::bank_wr_t   wr,
    input  wire la_pkg::bank_addr_t rd_addr,
    output la_pkg::byte_t           rd_data
);
    import la_pkg::*;

    byte_t mem [`LA_BANK_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr.addr] <= wr.data;
    end

    // Read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: verilog/capture_rd_ctrl.sv
// ****************************************
// Capture read controller
// Four-phase req/ack host port, reads both
// banks and rebuilds the stored sample
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "la_defines.svh"

module capture_rd_ctrl (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     store_wide,
    input  wire                     rd_req,
    input  wire la_pkg::addr_t      rd_addr,
    output logic                    rd_ack,
    output la_pkg::sample_t         rd_data,
    output la_pkg::bank_addr_t      bank_rd_addr,
    input  wire la_pkg::byte_t      bank0_data,
    input  wire la_pkg::byte_t      bank1_data
);
    import la_pkg::*;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_addr = 2'd1,
        st_read = 2'd2,
        st_ack  = 2'd3
    } rd_state_e;

    rd_state_e state;
    addr_t     addr_q;
    byte_t     sel_byte;

    // ****************************************
    // Handshake FSM
    // ****************************************
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state  <= st_idle;
            rd_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: if (rd_req) state <= st_addr;
                // Bank read in flight
                st_addr: state <= st_read;
                st_read: begin
                    state  <= st_ack;
                    rd_ack <= 1'b1;
                end
                default: begin
                    if (!rd_req) begin
                        state  <= st_idle;
                        rd_ack <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Address capture and word assembly
    always_ff @(posedge clk) begin
        if (state == st_idle && rd_req)
            addr_q <= rd_addr;
        if (state == st_read)
            rd_data <= store_wide ? {bank1_data, bank0_data} : sample_t'(sel_byte);
    end

    // Top address bit picks the bank in narrow mode
    assign sel_byte     = addr_q[`LA_ADDR_W-1] ? bank1_data : bank0_data;
    assign bank_rd_addr = addr_q[`LA_BANK_AW-1:0];

endmodule

`default_nettype wire

// File: verilog/logic_analyzer_top.sv
// ****************************************
// Logic analyzer top level
// Trigger, write split, two capture banks
// and the host read port
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module logic_analyzer_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire la_pkg::la_cfg_t    cfg,
    input  wire                     capture_start,
    input  wire                     capture_enable,
    input  wire la_pkg::sample_t    smp_data,
    input  wire                     smp_vld,
    input  wire                     cnt_clr,
    input  wire la_pkg::mem_wr_t    dbg_wr,
    input  wire                     rd_req,
    input  wire la_pkg::addr_t      rd_addr,
    output logic                    triggered,
    output la_pkg::addr_t           tri_addr,
    output la_pkg::addr_t           read_start_addr,
    output logic                    capture_done,
    output la_pkg::cnt_t            hit_cnt,
    output logic                    rd_ack,
    output la_pkg::sample_t         rd_data
);
    import la_pkg::*;

    mem_wr_t    tri_wr;
    bank_wr_t   bank0_wr;
    bank_wr_t   bank1_wr;
    bank_addr_t bank_rd_addr;
    byte_t      bank0_data;
    byte_t      bank1_data;

    trigger u_trigger (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg             (cfg),
        .capture_enable  (capture_enable),
        .capture_start   (capture_start),
        .smp_data        (smp_data),
        .smp_vld         (smp_vld),
        .cnt_clr         (cnt_clr),
        .tri_wr          (tri_wr),
        .triggered       (triggered),
        .tri_addr        (tri_addr),
        .read_start_addr (read_start_addr),
        .capture_done    (capture_done),
        .hit_cnt         (hit_cnt)
    );

    ram_wr_ctrl u_ram_wr_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .dbg_mode   (cfg.dbg_mode),
        .store_wide (cfg.store_wide),
        .tri_wr     (tri_wr),
        .dbg_wr     (dbg_wr),
        .bank0_wr   (bank0_wr),
        .bank1_wr   (bank1_wr)
    );

    // ****************************************
    // Capture banks
    // ****************************************
    capture_ram u_bank0 (
        .clk     (clk),
        .wr      (bank0_wr),
        .rd_addr (bank_rd_addr),
        .rd_data (bank0_data)
    );

    capture_ram u_bank1 (
        .clk     (clk),
        .wr      (bank1_wr),
        .rd_addr (bank_rd_addr),
        .rd_data (bank1_data)
    );

    capture_rd_ctrl u_capture_rd_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .store_wide   (cfg.store_wide),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .rd_ack       (rd_ack),
        .rd_data      (rd_data),
        .bank_rd_addr (bank_rd_addr),
        .bank0_data   (bank0_data),
        .bank1_data   (bank1_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
// ****************************************
// Testbench clock and reset
// 20 ns clock, reset held for three cycles
// ****************************************

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset is active high
    initial begin
        rst_n = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/tb_logic_analyzer.sv
// ****************************************
// Logic analyzer testbench
// Table-driven captures, debug writes and
// hit counter runs checked against a model
// ****************************************

`timescale 1ns/1ps
`default_nettype none

`include "la_defines.svh"

module tb_logic_analyzer;
    import la_pkg::*;

    typedef struct {
        string   name;
        la_cfg_t cfg;
        int      len;
        int      captures;
        int      inj;
        sample_t mask;
        sample_t val;
        logic    clr;
        logic    dbg;
        logic    exp_trig;
        logic    exp_done;
        addr_t   exp_tri;
        addr_t   exp_start;
    } test_row_t;

    localparam int NUM_ROWS = 7;

    logic    clk;
    logic    rst_n;
    la_cfg_t cfg;
    logic    capture_start;
    logic    capture_enable;
    sample_t smp_data;
    logic    smp_vld;
    logic    cnt_clr;
    mem_wr_t dbg_wr;
    logic    rd_req;
    addr_t   rd_addr;
    logic    triggered;
    addr_t   tri_addr;
    addr_t   read_start_addr;
    logic    capture_done;
    cnt_t    hit_cnt;
    logic    rd_ack;
    sample_t rd_data;

    test_row_t rows [NUM_ROWS];
    sample_t   stream_q [$];
    addr_t     dbg_addr_q [$];
    byte_t     mem0_m [`LA_BANK_DEPTH];
    byte_t     mem1_m [`LA_BANK_DEPTH];
    sample_t   prev_m;
    cnt_t      cnt_m;
    integer    seed = 7426;
    int        errors;
    int        checks;
    longint    limit_ns;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    logic_analyzer_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg             (cfg),
        .capture_start   (capture_start),
        .capture_enable  (capture_enable),
        .smp_data        (smp_data),
        .smp_vld         (smp_vld),
        .cnt_clr         (cnt_clr),
        .dbg_wr          (dbg_wr),
        .rd_req          (rd_req),
        .rd_addr         (rd_addr),
        .triggered       (triggered),
        .tri_addr        (tri_addr),
        .read_start_addr (read_start_addr),
        .capture_done    (capture_done),
        .hit_cnt         (hit_cnt),
        .rd_ack          (rd_ack),
        .rd_data         (rd_data)
    );

    // ****************************************
    // Compare tasks
    // ****************************************
    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_sample(string name, sample_t got, sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_cnt(string name, cnt_t got, cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h exp %h", name, got, exp);
        end
    endtask

    // ****************************************
    // Reference model
    // ****************************************
    function automatic logic model_match(la_cfg_t c, sample_t d, sample_t p);
        logic any_hit;
        logic all_hit;
        logic h;
        any_hit = 1'b0;
        all_hit = 1'b1;
        for (int b = 0; b < `LA_SAMPLE_W; b++) begin
            if (c.cond[b] != dont_care) begin
                if (c.cond[b] == level)
                    h = (d[b] == c.pattern[b]);
                else if (c.cond[b] == rise)
                    h = !p[b] && d[b];
                else
                    h = p[b] && !d[b];
                any_hit = any_hit | h;
                all_hit = all_hit & h;
            end
        end
        return c.or_logic ? any_hit : all_hit;
    endfunction

    // Every seventh stream slot is held off by capture_enable
    function automatic logic enable_at(int k);
        return (k % 7) != 3;
    endfunction

    task automatic model_write(addr_t a, sample_t d, logic wide);
        bank_addr_t ba;
        ba = a[`LA_BANK_AW-1:0];
        if (wide) begin
            mem0_m[ba] = d[7:0];
            mem1_m[ba] = d[15:8];
        end else if (a[`LA_ADDR_W-1]) begin
            mem1_m[ba] = d[7:0];
        end else begin
            mem0_m[ba] = d[7:0];
        end
    endtask

    function automatic sample_t model_read(addr_t a, logic wide);
        bank_addr_t ba;
        ba = a[`LA_BANK_AW-1:0];
        if (wide)
            return {mem1_m[ba], mem0_m[ba]};
        return a[`LA_ADDR_W-1] ? sample_t'(mem1_m[ba]) : sample_t'(mem0_m[ba]);
    endfunction

    // Model one capture over stream_q and fill the row's expected fields
    task automatic model_capture(int r);
        la_cfg_t c;
        logic    armed;
        logic    trig;
        addr_t   cur;
        addr_t   pre;
        addr_t   post;
        int      span;
        c = rows[r].cfg;
        armed = 1'b1;
        trig = 1'b0;
        cur = '0;
        pre = '0;
        post = '0;
        span = int'(c.max_addr) + 1;
        foreach (stream_q[k]) begin
            if (armed && enable_at(k)) begin
                model_write(cur, stream_q[k], c.store_wide);
                if (!trig) begin
                    if (pre == c.pre_num && model_match(c, stream_q[k], prev_m)) begin
                        trig = 1'b1;
                        rows[r].exp_tri = cur;
                        rows[r].exp_start = addr_t'((int'(cur) - int'(c.pre_num) + span) % span);
                        if (c.cnt_wrap || cnt_m != '1)
                            cnt_m = cnt_m + cnt_t'(1);
                        if (c.max_addr == c.pre_num)
                            armed = 1'b0;
                    end else if (pre != c.pre_num) begin
                        pre = pre + addr_t'(1);
                    end
                end else begin
                    post = post + addr_t'(1);
                    if (post == c.max_addr - c.pre_num)
                        armed = 1'b0;
                end
                cur = (cur == c.max_addr) ? '0 : cur + addr_t'(1);
            end
            prev_m = stream_q[k];
        end
        rows[r].exp_trig = trig;
        rows[r].exp_done = trig && !armed;
    endtask

    // ****************************************
    // Stimulus table
    // ****************************************
    function automatic la_cfg_t base_cfg(addr_t max_addr, addr_t pre_num, logic wide);
        la_cfg_t c;
        c = '0;
        c.max_addr   = max_addr;
        c.pre_num    = pre_num;
        c.store_wide = wide;
        return c;
    endfunction

    task automatic set_row(int r, string name, la_cfg_t c, int len, int captures,
                           int inj, sample_t mask, sample_t val, logic clr, logic dbg);
        rows[r].name      = name;
        rows[r].cfg       = c;
        rows[r].len       = len;
        rows[r].captures  = captures;
        rows[r].inj       = inj;
        rows[r].mask      = mask;
        rows[r].val       = val;
        rows[r].clr       = clr;
        rows[r].dbg       = dbg;
        rows[r].exp_trig  = 1'b0;
        rows[r].exp_done  = 1'b0;
        rows[r].exp_tri   = '0;
        rows[r].exp_start = '0;
    endtask

    task automatic build_table();
        la_cfg_t c;
        c = base_cfg(10'd63, 10'd8, 1'b1);
        c.pattern = 16'h000A;
        for (int b = 0; b < 4; b++)
            c.cond[b] = level;
        set_row(0, "level_and_wide", c, 120, 1, 30, 16'h000F, 16'h000A, 1'b0, 1'b0);
        c = base_cfg(10'd47, 10'd16, 1'b1);
        c.cond[15] = rise;
        c.cond[14] = fall;
        c.or_logic = 1'b1;
        set_row(1, "edge_or_wide", c, 100, 1, 40, 16'hC000, 16'h8000, 1'b0, 1'b0);
        c = base_cfg(10'd1023, 10'd100, 1'b0);
        c.pattern = 16'h005A;
        for (int b = 0; b < 8; b++)
            c.cond[b] = level;
        set_row(2, "narrow_1024", c, 1400, 1, 300, 16'h00FF, 16'h005A, 1'b0, 1'b0);
        c = base_cfg('0, '0, 1'b1);
        c.dbg_mode = 1'b1;
        set_row(3, "debug_direct", c, 24, 0, 0, '0, '0, 1'b0, 1'b1);
        // Every capture hits in a single-sample window with no care bits
        c = base_cfg('0, '0, 1'b1);
        set_row(4, "cnt_saturate", c, 1, 300, 0, '0, '0, 1'b1, 1'b0);
        c.cnt_wrap = 1'b1;
        set_row(5, "cnt_wrap", c, 1, 20, 0, '0, '0, 1'b0, 1'b0);
        c.cnt_wrap = 1'b0;
        set_row(6, "cnt_clear", c, 1, 3, 0, '0, '0, 1'b1, 1'b0);
    endtask

    // ****************************************
    // Drivers
    // ****************************************
    task automatic make_stream(int r);
        int i;
        stream_q.delete();
        for (int k = 0; k < rows[r].len; k++)
            stream_q.push_back(sample_t'($random(seed)));
        if (rows[r].mask != '0) begin
            i = rows[r].inj;
            // Edge conditions need the opposite level one sample earlier
            stream_q[i-1] = (stream_q[i-1] & ~rows[r].mask) | (~rows[r].val & rows[r].mask);
            stream_q[i] = (stream_q[i] & ~rows[r].mask) | (rows[r].val & rows[r].mask);
        end
    endtask

    task automatic drive_capture(int r);
        int n;
        @(posedge clk);
        capture_start <= 1'b1;
        @(posedge clk);
        capture_start <= 1'b0;
        foreach (stream_q[k]) begin
            @(posedge clk);
            smp_data       <= stream_q[k];
            smp_vld        <= 1'b1;
            capture_enable <= enable_at(k);
        end
        @(posedge clk);
        smp_vld        <= 1'b0;
        capture_enable <= 1'b1;
        if (rows[r].exp_done) begin
            n = 0;
            @(negedge clk);
            while (!capture_done && n < 8) begin
                @(negedge clk);
                n++;
            end
            if (!capture_done) begin
                errors++;
                $display("capture_done did not rise after the window filled in test %0d", r);
            end
        end
    endtask

    task automatic read_word(addr_t a, output sample_t d);
        int n;
        @(posedge clk);
        rd_addr <= a;
        rd_req  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!rd_ack && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!rd_ack) begin
            errors++;
            $display("rd_ack did not rise for read address %h", a);
        end
        d = rd_data;
        @(posedge clk);
        rd_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (rd_ack && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (rd_ack) begin
            errors++;
            $display("rd_ack stayed high after rd_req dropped at address %h", a);
        end
    endtask

    task automatic run_debug(int r);
        addr_t   a;
        sample_t d;
        dbg_addr_q.delete();
        for (int k = 0; k < rows[r].len; k++) begin
            a = addr_t'($random(seed));
            d = sample_t'($random(seed));
            dbg_addr_q.push_back(a);
            model_write(a, d, rows[r].cfg.store_wide);
            @(posedge clk);
            dbg_wr <= '{vld: 1'b1, addr: a, data: d};
        end
        @(posedge clk);
        dbg_wr <= '0;
        repeat (4) @(posedge clk);
        foreach (dbg_addr_q[k]) begin
            read_word(dbg_addr_q[k], d);
            check_sample($sformatf("rd_data@%h", dbg_addr_q[k]), d,
                         model_read(dbg_addr_q[k], rows[r].cfg.store_wide));
        end
        @(negedge clk);
        check_cnt("hit_cnt", hit_cnt, cnt_m);
    endtask

    task automatic check_capture(int r);
        addr_t   a;
        sample_t d;
        int      span;
        @(negedge clk);
        check_flag("triggered", triggered, rows[r].exp_trig);
        check_flag("capture_done", capture_done, rows[r].exp_done);
        check_addr("tri_addr", tri_addr, rows[r].exp_tri);
        check_addr("read_start_addr", read_start_addr, rows[r].exp_start);
        check_cnt("hit_cnt", hit_cnt, cnt_m);
        if (rows[r].exp_trig) begin
            span = int'(rows[r].cfg.max_addr) + 1;
            // Window in capture order from the oldest sample
            for (int k = 0; k < span; k++) begin
                a = addr_t'((int'(rows[r].exp_start) + k) % span);
                read_word(a, d);
                check_sample($sformatf("rd_data@%h", a), d,
                             model_read(a, rows[r].cfg.store_wide));
            end
        end
    endtask

    task automatic run_row(int r);
        int err_start;
        err_start = errors;
        if (rows[r].clr) begin
            @(posedge clk);
            cnt_clr <= 1'b1;
            @(posedge clk);
            cnt_clr <= 1'b0;
            cnt_m = '0;
        end
        @(posedge clk);
        cfg <= rows[r].cfg;
        repeat (2) @(posedge clk);
        if (rows[r].dbg) begin
            run_debug(r);
        end else begin
            for (int c = 0; c < rows[r].captures; c++) begin
                make_stream(r);
                model_capture(r);
                drive_capture(r);
            end
            check_capture(r);
        end
        $display("test %0d %s: %s", r, rows[r].name, (errors == err_start) ? "pass" : "fail");
    endtask

    // ****************************************
    // Watchdog and main sequence
    // ****************************************
    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout: run went past %0d ns without finishing", limit_ns);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        longint cycles;
        cfg            = '0;
        capture_start  = 1'b0;
        capture_enable = 1'b1;
        smp_data       = '0;
        smp_vld        = 1'b0;
        cnt_clr        = 1'b0;
        dbg_wr         = '0;
        rd_req         = 1'b0;
        rd_addr        = '0;
        errors         = 0;
        checks         = 0;
        prev_m         = '0;
        cnt_m          = '0;
        limit_ns       = 0;
        build_table();
        // Samples plus read handshakes with a margin of four
        cycles = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycles += rows[r].captures * (rows[r].len + 12) + 20;
            cycles += (int'(rows[r].cfg.max_addr) + 1 + (rows[r].dbg ? rows[r].len : 0)) * 8;
        end
        limit_ns = cycles * 20 * 4;
        wait (rst_n === 1'b0);
        @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("tests %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+verilog
verilog/la_pkg.sv
verilog/trigger.sv
verilog/ram_wr_ctrl.sv
verilog/capture_ram.sv
verilog/capture_rd_ctrl.sv
verilog/logic_analyzer_top.sv
tb/tb_clkgen.sv
tb/tb_logic_analyzer.sv

// File: Makefile
VERILATOR ?= verilator

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f project.f --top-module logic_analyzer_top

sim:
	$(VERILATOR) --binary --timing -f project.f --top-module tb_logic_analyzer -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_logic_analyzer); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
